// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := mini_pod_tb
FILELIST  := sim.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := ALL CHECKS PASSED

.PHONY: run clean

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/mini_pod_checker.sv ====
// response checker: matches pod responses to their requests by tag and checks per-bank order
`timescale 1ns/1ps

module mini_pod_checker #(
  parameter int num_banks_p = 4
) (
  input  logic                           clk_i,
  input  logic                           req_v_i,
  input  logic                           req_ready_i,
  input  pod_pkg::req_pkt_t              req_i,
  input  logic [pod_pkg::data_width-1:0] exp_data_i,
  input  logic                           exp_chk_i,
  input  logic                           rsp_v_i,
  input  logic                           rsp_ready_i,
  input  pod_pkg::rsp_pkt_t              rsp_i,
  output int                             outstanding_o,
  output int                             err_cnt_o
);

  localparam int tags_lp = 2 ** pod_pkg::tag_width;

  logic                           pending [tags_lp];
  pod_pkg::mem_op_e               exp_op [tags_lp];
  logic [pod_pkg::data_width-1:0] exp_data [tags_lp];
  logic                           exp_chk [tags_lp];
  int                             tag_bank [tags_lp];
  int                             tag_seq [tags_lp];
  int                             issued [num_banks_p];
  int                             retired [num_banks_p];

  initial begin
    outstanding_o = 0;
    err_cnt_o     = 0;
    for (int i = 0; i < tags_lp; i++) begin
      pending[i] = 1'b0;
    end
    for (int b = 0; b < num_banks_p; b++) begin
      issued[b]  = 0;
      retired[b] = 0;
    end
  end

  // sampled mid-cycle, everything settled by then
  always @(negedge clk_i) begin
    int t;
    int b;
    if (rsp_v_i && rsp_ready_i) begin
      t = int'(rsp_i.tag);
      if (!pending[t]) begin
        $display("%0t: response with tag %0d has no request waiting for it", $time, t);
        err_cnt_o++;
      end else begin
        b = tag_bank[t];
        if (rsp_i.op !== exp_op[t]) begin
          $display("FAILED at %0t: rsp_o.op for tag %0d expected %0d got %0d",
                   $time, t, exp_op[t], rsp_i.op);
          err_cnt_o++;
        end
        if (exp_chk[t] && rsp_i.data !== exp_data[t]) begin
          $display("FAILED at %0t: rsp_o.data for tag %0d expected %h got %h",
                   $time, t, exp_data[t], rsp_i.data);
          err_cnt_o++;
        end
        // one bank answers in the order it accepted
        if (tag_seq[t] != retired[b]) begin
          $display("%0t: tag %0d left bank %0d out of issue order", $time, t, b);
          err_cnt_o++;
        end
        retired[b]++;
        pending[t] = 1'b0;
        outstanding_o--;
      end
    end
    if (req_v_i && req_ready_i) begin
      t = int'(req_i.tag);
      b = int'(req_i.addr) % num_banks_p;
      if (pending[t]) begin
        $display("%0t: tag %0d sent again before its response came back", $time, t);
        err_cnt_o++;
      end
      pending[t]  = 1'b1;
      exp_op[t]   = req_i.op;
      exp_data[t] = exp_data_i;
      exp_chk[t]  = exp_chk_i;
      tag_bank[t] = b;
      tag_seq[t]  = issued[b];
      issued[b]++;
      outstanding_o++;
    end
  end

endmodule

// ==== dv/mini_pod_golden.txt ====
# T <test name> <back-pressure 0 or 1>
# R <op 0 load 1 store 2 add> <addr> <data> <tag> <expected old word> <compare data 0 or 1>
T store_load 0
R 1 0000 11110000 00 00000000 0
R 1 0001 22220001 01 00000000 0
R 1 0002 33330002 02 00000000 0
R 1 0003 44440003 03 00000000 0
R 1 0000 55550000 04 11110000 1
R 0 0003 00000000 05 44440003 1
T fetch_add 0
R 2 0001 ffffffff 00 22220001 1
R 0 0001 00000000 01 22220000 1
R 2 0000 00000003 02 55550000 1
T spread_banks 0
R 0 0002 00000000 00 33330002 1
R 0 0000 00000000 01 55550003 1
R 0 0003 00000000 02 44440003 1
R 0 0001 00000000 03 22220000 1
T one_bank_burst 0
R 1 0006 b0000006 00 00000000 0
R 2 0006 00000100 01 b0000006 1
R 0 0006 00000000 02 b0000106 1
R 0 0002 00000000 03 33330002 1
T back_pressure 1
R 2 0003 00000001 00 44440003 1
R 0 0003 00000000 01 44440004 1
R 0 0000 00000000 02 55550003 1
R 0 0001 00000000 03 22220000 1
R 0 0006 00000000 04 b0000106 1

// ==== dv/mini_pod_tb.sv ====
// mini pod testbench replaying the golden request file and draining every response
`timescale 1ns/1ps

module mini_pod_tb;

  logic                           core_clk = 1'b0;
  logic                           rst_n;
  logic                           req_v;
  pod_pkg::req_pkt_t              req;
  logic                           req_ready;
  logic                           rsp_v;
  pod_pkg::rsp_pkt_t              rsp;
  logic                           rsp_ready;
  logic [pod_pkg::data_width-1:0] exp_data;
  logic                           exp_chk;
  logic                           bp_on = 1'b0;
  int                             outstanding;
  int                             err_cnt;
  int                             cycles = 0;
  int                             limit = 0;

  pod_pkg::req_pkt_t              req_q[$];
  logic [pod_pkg::data_width-1:0] exp_q[$];
  logic                           chk_q[$];
  string                          test_name[$];
  int                             test_bp[$];
  int                             test_first[$];

  mini_pod_top i_mini_pod_top (
    .clk_i      (core_clk),
    .rst_n_i    (rst_n),
    .req_v_i    (req_v),
    .req_i      (req),
    .req_ready_o(req_ready),
    .rsp_v_o    (rsp_v),
    .rsp_o      (rsp),
    .rsp_ready_i(rsp_ready)
  );

  mini_pod_checker i_mini_pod_checker (
    .clk_i        (core_clk),
    .req_v_i      (req_v),
    .req_ready_i  (req_ready),
    .req_i        (req),
    .exp_data_i   (exp_data),
    .exp_chk_i    (exp_chk),
    .rsp_v_i      (rsp_v),
    .rsp_ready_i  (rsp_ready),
    .rsp_i        (rsp),
    .outstanding_o(outstanding),
    .err_cnt_o    (err_cnt)
  );

  always #50 core_clk = ~core_clk;

  // random host back-pressure in tests that enable it
  always @(posedge core_clk) begin
    bit hold;
    hold = bp_on && ($urandom % 3 == 0);
    #1;
    rsp_ready = !hold;
  end

  always @(posedge core_clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run stopped after %0d cycles with %0d responses missing",
               cycles, outstanding);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic read_golden(output bit ok);
    int                fd;
    string             line;
    string             name;
    int                bp;
    logic [31:0]       op;
    logic [31:0]       addr;
    logic [31:0]       data;
    logic [31:0]       tag;
    logic [31:0]       exp;
    logic [31:0]       chk;
    pod_pkg::req_pkt_t r;
    ok = 1'b0;
    fd = $fopen("dv/mini_pod_golden.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.substr(0, 0) == "T") begin
          void'($sscanf(line, "T %s %d", name, bp));
          test_name.push_back(name);
          test_bp.push_back(bp);
          test_first.push_back(req_q.size());
        end else if (line.substr(0, 0) == "R") begin
          void'($sscanf(line, "R %h %h %h %h %h %h", op, addr, data, tag, exp, chk));
          r.op   = pod_pkg::mem_op_e'(op[1:0]);
          r.tag  = tag[pod_pkg::tag_width-1:0];
          r.addr = addr[pod_pkg::addr_width-1:0];
          r.data = data;
          req_q.push_back(r);
          exp_q.push_back(exp);
          chk_q.push_back(chk[0]);
        end
      end
      $fclose(fd);
      // end marker of the last test
      test_first.push_back(req_q.size());
      ok = (req_q.size() > 0);
    end
  endtask

  // entered and left 1 ns after a rising edge
  task automatic send_req(input int i);
    bit xfer;
    req_v    = 1'b1;
    req      = req_q[i];
    exp_data = exp_q[i];
    exp_chk  = chk_q[i];
    do begin
      @(negedge core_clk);
      xfer = req_ready;
      @(posedge core_clk);
      #1;
    end while (!xfer);
    req_v = 1'b0;
  endtask

  task automatic run_test(input int t, output bit passed);
    int errs_before;
    errs_before = err_cnt;
    bp_on = test_bp[t][0];
    for (int i = test_first[t]; i < test_first[t + 1]; i++) begin
      send_req(i);
    end
    while (outstanding != 0) begin
      @(posedge core_clk);
      #1;
    end
    bp_on  = 1'b0;
    passed = (err_cnt == errs_before);
    if (passed) begin
      $display("test %s: passed", test_name[t]);
    end else begin
      $display("test %s: failed with %0d errors", test_name[t], err_cnt - errs_before);
    end
  endtask

  initial begin
    bit ok;
    bit passed;
    int n_pass;
    int n_fail;
    void'($urandom(32'h15a1));
    rst_n     = 1'b0;
    req_v     = 1'b0;
    req       = '0;
    rsp_ready = 1'b1;
    exp_data  = '0;
    exp_chk   = 1'b0;
    n_pass    = 0;
    n_fail    = 0;
    read_golden(ok);
    if (!ok) begin
      $display("golden file dv/mini_pod_golden.txt is missing or holds no requests");
      $display("CHECKS FAILED");
    end else begin
      limit = req_q.size() * 20 + 200;
      repeat (4) @(posedge core_clk);
      #1;
      rst_n = 1'b1;
      for (int t = 0; t < test_name.size(); t++) begin
        run_test(t, passed);
        if (passed) begin
          n_pass++;
        end else begin
          n_fail++;
        end
      end
      $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, err_cnt);
      if (n_fail == 0 && err_cnt == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
    end
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/pod_pkg.sv
verilog/bank_router.sv
verilog/mem_bank.sv
verilog/return_arbiter.sv
verilog/return_credit_fifo.sv
verilog/mini_pod_top.sv
dv/mini_pod_checker.sv
dv/mini_pod_tb.sv

// ==== verilog/bank_router.sv ====
// bank router: steers each host request to the bank named by its low address bits
`timescale 1ns/1ps

module bank_router #(
  parameter int num_banks_p = 4
) (
  input  logic                   req_v_i,
  input  pod_pkg::req_pkt_t      req_i,
  output logic                   req_ready_o,

  output logic [num_banks_p-1:0] bank_v_o,
  output pod_pkg::req_pkt_t      bank_req_o,
  input  logic [num_banks_p-1:0] bank_ready_i
);

  localparam int bank_bits_lp = $clog2(num_banks_p);

  logic [bank_bits_lp-1:0] bank_sel;

  assign bank_sel = req_i.addr[bank_bits_lp-1:0];

  // only the addressed bank sees valid
  always_comb begin
    bank_v_o           = '0;
    bank_v_o[bank_sel] = req_v_i;
  end

  // word index within the bank
  always_comb begin
    bank_req_o      = req_i;
    bank_req_o.addr = req_i.addr >> bank_bits_lp;
  end

  assign req_ready_o = bank_ready_i[bank_sel];

endmodule

// ==== verilog/mem_bank.sv ====
// memory bank: word-addressed storage doing load, store and fetch-add with a response register
`timescale 1ns/1ps

module mem_bank #(
  parameter int bank_words_p = 16
) (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  logic              req_v_i,
  input  pod_pkg::req_pkt_t req_i,
  output logic              req_ready_o,

  output logic              rsp_v_o,
  output pod_pkg::rsp_pkt_t rsp_o,
  input  logic              rsp_yumi_i
);

  localparam int idx_bits_lp = $clog2(bank_words_p);

  logic [pod_pkg::data_width-1:0] mem_q [bank_words_p];
  logic [idx_bits_lp-1:0]         idx;
  logic [pod_pkg::data_width-1:0] old_word;
  logic                           accept;
  logic                           rsp_v_q;
  pod_pkg::rsp_pkt_t              rsp_q;

  assign idx      = req_i.addr[idx_bits_lp-1:0];
  assign old_word = mem_q[idx];

  // free slot, or the held response leaves this cycle
  assign req_ready_o = ~rsp_v_q | rsp_yumi_i;
  assign accept      = req_v_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      case (req_i.op)
        pod_pkg::op_store: mem_q[idx] <= req_i.data;
        pod_pkg::op_add:   mem_q[idx] <= old_word + req_i.data;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.op   <= req_i.op;
      rsp_q.tag  <= req_i.tag;
      rsp_q.data <= old_word;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_v_q <= 1'b0;
    end else if (accept) begin
      rsp_v_q <= 1'b1;
    end else if (rsp_yumi_i) begin
      rsp_v_q <= 1'b0;
    end
  end

  assign rsp_v_o = rsp_v_q;
  assign rsp_o   = rsp_q;

endmodule

// ==== verilog/mini_pod_top.sv ====
// mini pod top: host request router, bank array, response arbiter and return FIFO
`timescale 1ns/1ps

module mini_pod_top #(
  parameter int num_banks_p    = 4,
  parameter int bank_words_p   = 16,
  parameter int ret_fifo_els_p = 3
) (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  logic              req_v_i,
  input  pod_pkg::req_pkt_t req_i,
  output logic              req_ready_o,

  output logic              rsp_v_o,
  output pod_pkg::rsp_pkt_t rsp_o,
  input  logic              rsp_ready_i
);

  logic              [num_banks_p-1:0] bank_v;
  pod_pkg::req_pkt_t                   bank_req;
  logic              [num_banks_p-1:0] bank_ready;
  logic              [num_banks_p-1:0] bank_rsp_v;
  pod_pkg::rsp_pkt_t [num_banks_p-1:0] bank_rsp;
  logic              [num_banks_p-1:0] bank_yumi;
  logic                                enq_v;
  pod_pkg::rsp_pkt_t                   enq;
  logic                                credit;

  bank_router #(
    .num_banks_p(num_banks_p)
  ) i_bank_router (
    .req_v_i     (req_v_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .bank_v_o    (bank_v),
    .bank_req_o  (bank_req),
    .bank_ready_i(bank_ready)
  );

  // request bus is shared, only valid is per bank
  for (genvar g = 0; g < num_banks_p; g++) begin : g_bank
    mem_bank #(
      .bank_words_p(bank_words_p)
    ) i_mem_bank (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_v_i    (bank_v[g]),
      .req_i      (bank_req),
      .req_ready_o(bank_ready[g]),
      .rsp_v_o    (bank_rsp_v[g]),
      .rsp_o      (bank_rsp[g]),
      .rsp_yumi_i (bank_yumi[g])
    );
  end

  return_arbiter #(
    .num_banks_p   (num_banks_p),
    .ret_fifo_els_p(ret_fifo_els_p)
  ) i_return_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bank_rsp_v_i(bank_rsp_v),
    .bank_rsp_i  (bank_rsp),
    .bank_yumi_o (bank_yumi),
    .enq_v_o     (enq_v),
    .enq_o       (enq),
    .credit_i    (credit)
  );

  return_credit_fifo #(
    .ret_fifo_els_p(ret_fifo_els_p)
  ) i_return_credit_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .enq_v_i    (enq_v),
    .enq_i      (enq),
    .rsp_v_o    (rsp_v_o),
    .rsp_o      (rsp_o),
    .rsp_ready_i(rsp_ready_i),
    .credit_o   (credit)
  );

endmodule

// ==== verilog/pod_pkg.sv ====
// pod package: shared widths, memory op encoding and packet formats of the memory pod
package pod_pkg;

  // word carried by requests and responses
  localparam int data_width = 32;

  // word address as sent by the host, bank bits included
  localparam int addr_width = 16;

  // request id, echoed back in the response
  localparam int tag_width  = 6;

  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_store = 2'd1,
    op_add   = 2'd2
  } mem_op_e;

  // host to bank
  typedef struct packed {
    mem_op_e               op;
    logic [tag_width-1:0]  tag;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } req_pkt_t;

  // bank to host
  // data is the word as it was before the op
  typedef struct packed {
    mem_op_e               op;
    logic [tag_width-1:0]  tag;
    logic [data_width-1:0] data;
  } rsp_pkt_t;

endpackage

// ==== verilog/return_arbiter.sv ====
// return arbiter: round-robin merge of bank responses, limited by return FIFO credits
`timescale 1ns/1ps

module return_arbiter #(
  parameter int num_banks_p    = 4,
  parameter int ret_fifo_els_p = 3
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  logic              [num_banks_p-1:0]   bank_rsp_v_i,
  input  pod_pkg::rsp_pkt_t [num_banks_p-1:0]   bank_rsp_i,
  output logic              [num_banks_p-1:0]   bank_yumi_o,

  output logic                                  enq_v_o,
  output pod_pkg::rsp_pkt_t                     enq_o,
  input  logic                                  credit_i
);

  localparam int sel_bits_lp  = $clog2(num_banks_p);
  localparam int cred_bits_lp = $clog2(ret_fifo_els_p + 1);

  logic [sel_bits_lp-1:0]  last_q;
  logic [sel_bits_lp-1:0]  win;
  logic                    found;
  logic                    grant;
  logic [cred_bits_lp-1:0] credit_q;

  // search starts just after the last winner, which comes last
  always_comb begin
    logic [sel_bits_lp-1:0] idx;
    win   = last_q;
    found = 1'b0;
    for (int i = 1; i <= num_banks_p; i++) begin
      idx = last_q + sel_bits_lp'(i);
      if (!found && bank_rsp_v_i[idx]) begin
        win   = idx;
        found = 1'b1;
      end
    end
  end

  assign grant = found & (credit_q != '0);

  always_comb begin
    bank_yumi_o      = '0;
    bank_yumi_o[win] = grant;
  end

  assign enq_v_o = grant;
  assign enq_o   = bank_rsp_i[win];

  // one credit per free FIFO slot
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= cred_bits_lp'(ret_fifo_els_p);
      last_q   <= '1;
    end else begin
      credit_q <= credit_q - cred_bits_lp'(grant) + cred_bits_lp'(credit_i);
      if (grant) begin
        last_q <= win;
      end
    end
  end

endmodule

// ==== verilog/return_credit_fifo.sv ====
// return credit FIFO: buffers responses toward the host and returns one credit per dequeue
`timescale 1ns/1ps

module return_credit_fifo #(
  parameter int ret_fifo_els_p = 3
) (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  logic              enq_v_i,
  input  pod_pkg::rsp_pkt_t enq_i,

  output logic              rsp_v_o,
  output pod_pkg::rsp_pkt_t rsp_o,
  input  logic              rsp_ready_i,

  output logic              credit_o
);

  localparam int ptr_bits_lp = (ret_fifo_els_p > 1) ? $clog2(ret_fifo_els_p) : 1;
  localparam int cnt_bits_lp = $clog2(ret_fifo_els_p + 1);
  localparam logic [ptr_bits_lp-1:0] last_ptr_lp = ptr_bits_lp'(ret_fifo_els_p - 1);

  pod_pkg::rsp_pkt_t      mem_q [ret_fifo_els_p];
  logic [ptr_bits_lp-1:0] rd_ptr_q;
  logic [ptr_bits_lp-1:0] wr_ptr_q;
  logic [cnt_bits_lp-1:0] count_q;
  logic                   deq;
  logic                   credit_q;

  assign rsp_v_o = (count_q != '0);
  assign rsp_o   = mem_q[rd_ptr_q];
  assign deq     = rsp_v_o & rsp_ready_i;

  // credits upstream keep enq away from a full FIFO
  always_ff @(posedge clk_i) begin
    if (enq_v_i) begin
      mem_q[wr_ptr_q] <= enq_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (enq_v_i) begin
        wr_ptr_q <= (wr_ptr_q == last_ptr_lp) ? '0 : wr_ptr_q + 1'b1;
      end
      if (deq) begin
        rd_ptr_q <= (rd_ptr_q == last_ptr_lp) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + cnt_bits_lp'(enq_v_i) - cnt_bits_lp'(deq);
      // dequeue handshake registered into a credit
      credit_q <= deq;
    end
  end

  assign credit_o = credit_q;

endmodule
